//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cache_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
design/cache_pkg.sv
design/cache_ram.sv
design/fill_counter.sv
design/cache_ctrl.sv
design/cache_top.sv
tb/tb_clkgen.sv
tb/cache_chk.sv
tb/cache_tb.sv

//--- design/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
   input  wire                                         clk_i,
   input  wire                                         arst_n_i,
   input  wire cache_pkg::fe_req_t                     fe_req_i,
   output cache_pkg::fe_rsp_t                          fe_rsp_o,
   output cache_pkg::be_req_t                          be_req_o,
   input  wire cache_pkg::be_rsp_t                     be_rsp_i,
   input  wire                                         invalidate_i,
   output cache_pkg::stat_t                            stat_o,
   output logic                                        tag_en_o,
   output logic                                        tag_we_o,
   output logic [cache_pkg::INDEX_W-1:0]               tag_addr_o,
   output cache_pkg::tag_entry_t                       tag_d_o,
   input  wire cache_pkg::tag_entry_t                  tag_q_i,
   output logic                                        data_en_o,
   output logic                                        data_we_o,
   output logic [cache_pkg::INDEX_W+cache_pkg::OFFSET_W-1:0] data_addr_o,
   output cache_pkg::word_t                            data_d_o,
   input  wire cache_pkg::word_t                       data_q_i,
   output logic                                        cnt_clear_o,
   output logic                                        cnt_inc_o,
   input  wire [cache_pkg::OFFSET_W-1:0]               cnt_i,
   input  wire                                         cnt_last_i
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOOKUP,
      S_FILL_REQ,
      S_FILL_WAIT,
      S_REPLY,
      S_WRITE
   } state_t;

   state_t                              state_q;
   state_t                              state_d;
   cache_pkg::fe_req_t                  req_q;
   cache_pkg::word_t                    rword_q;
   logic [(1<<cache_pkg::INDEX_W)-1:0]  valid_q;
   logic                                accept;
   logic                                lookup;
   logic                                hit;
   logic                                fill_word;

   assign accept    = (state_q == S_IDLE) && fe_req_i.avalid;
   assign lookup    = (state_q == S_LOOKUP);
   // tag compare, qualified by the line's valid bit
   assign hit       = valid_q[req_q.addr.index] && (tag_q_i == req_q.addr.tag);
   assign fill_word = (state_q == S_FILL_WAIT) && be_rsp_i.rvalid;

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE:      if (fe_req_i.avalid) state_d = S_LOOKUP;
         S_LOOKUP: begin
            if (req_q.we) begin
               state_d = S_WRITE;
            end else if (hit) begin
               state_d = S_IDLE;
            end else begin
               state_d = S_FILL_REQ;
            end
         end
         S_FILL_REQ:  if (be_rsp_i.ready) state_d = S_FILL_WAIT;
         S_FILL_WAIT: begin
            if (be_rsp_i.rvalid) begin
               state_d = cnt_last_i ? S_REPLY : S_FILL_REQ;
            end
         end
         S_REPLY:     state_d = S_IDLE;
         S_WRITE:     if (be_rsp_i.ready) state_d = S_IDLE;
         default:     state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= S_IDLE;
         valid_q <= '0;
      end else begin
         state_q <= state_d;
         if ((state_q == S_IDLE) && invalidate_i) begin
            valid_q <= '0;
         end else if (fill_word && cnt_last_i) begin
            valid_q[req_q.addr.index] <= 1'b1;
         end
      end
   end

   // request register and the word picked out of the refill
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= fe_req_i;
      end
      if (fill_word && (cnt_i == req_q.addr.offset)) begin
         rword_q <= be_rsp_i.rdata;
      end
   end

   // front end
   assign fe_rsp_o.ready  = (state_q == S_IDLE);
   assign fe_rsp_o.rvalid = (lookup && !req_q.we && hit) || (state_q == S_REPLY);
   assign fe_rsp_o.rdata  = (state_q == S_REPLY) ? rword_q : data_q_i;

   assign stat_o.rd_hit  = lookup && !req_q.we && hit;
   assign stat_o.rd_miss = lookup && !req_q.we && !hit;
   assign stat_o.wr_hit  = lookup && req_q.we && hit;
   assign stat_o.wr_miss = lookup && req_q.we && !hit;

   // back end, refill words go out at line offsets 0 to 3
   always_comb begin
      be_req_o.avalid      = (state_q == S_FILL_REQ) || (state_q == S_WRITE);
      be_req_o.we          = (state_q == S_WRITE);
      be_req_o.addr        = req_q.addr;
      be_req_o.wdata       = req_q.wdata;
      if (state_q != S_WRITE) begin
         be_req_o.addr.offset = cnt_i;
      end
   end

   // tag memory
   assign tag_we_o   = fill_word && cnt_last_i;
   assign tag_en_o   = accept || tag_we_o;
   assign tag_addr_o = (state_q == S_IDLE) ? fe_req_i.addr.index : req_q.addr.index;
   assign tag_d_o    = req_q.addr.tag;

   // data memory, write hit in lookup or refill word
   assign data_we_o = (lookup && req_q.we && hit) || fill_word;
   assign data_en_o = accept || data_we_o;
   assign data_d_o  = lookup ? req_q.wdata : be_rsp_i.rdata;

   always_comb begin
      if (state_q == S_IDLE) begin
         data_addr_o = {fe_req_i.addr.index, fe_req_i.addr.offset};
      end else if (lookup) begin
         data_addr_o = {req_q.addr.index, req_q.addr.offset};
      end else begin
         data_addr_o = {req_q.addr.index, cnt_i};
      end
   end

   assign cnt_clear_o = lookup;
   assign cnt_inc_o   = fill_word;

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

   // cache geometry
   localparam int ADDR_W   = 10;
   localparam int TAG_W    = 4;
   localparam int INDEX_W  = 4;
   localparam int OFFSET_W = 2;
   localparam int DATA_W   = 32;
   localparam int NWORDS   = 4;

   typedef logic [DATA_W-1:0] word_t;

   // word address split into its fields, tag on top
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } addr_t;

   typedef struct packed {
      logic  avalid;
      logic  we;
      addr_t addr;
      word_t wdata;
   } fe_req_t;

   typedef struct packed {
      logic  ready;
      logic  rvalid;
      word_t rdata;
   } fe_rsp_t;

   typedef struct packed {
      logic  avalid;
      logic  we;
      addr_t addr;
      word_t wdata;
   } be_req_t;

   typedef struct packed {
      logic  ready;
      logic  rvalid;
      word_t rdata;
   } be_rsp_t;

   typedef logic [TAG_W-1:0] tag_entry_t;

   // monitor pulses, one per looked-up request
   typedef struct packed {
      logic rd_hit;
      logic rd_miss;
      logic wr_hit;
      logic wr_miss;
   } stat_t;

endpackage

`default_nettype wire

//--- design/cache_ram.sv
`timescale 1ns/1ns
`default_nettype none

// single-port memory, registered read
module cache_ram #(
   parameter type entry_t   = logic,
   parameter int  ADDR_BITS = 4
) (
   input  wire                 clk_i,
   input  wire                 en_i,
   input  wire                 we_i,
   input  wire [ADDR_BITS-1:0] addr_i,
   input  wire entry_t         d_i,
   output entry_t              q_o
);

   localparam int DEPTH = 1 << ADDR_BITS;

   entry_t mem [DEPTH];

   // read returns the old contents on a write
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            mem[addr_i] <= d_i;
         end
         q_o <= mem[addr_i];
      end
   end

endmodule

`default_nettype wire

//--- design/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top (
   input  wire                     clk_i,
   input  wire                     arst_n_i,
   input  wire cache_pkg::fe_req_t fe_req_i,
   output cache_pkg::fe_rsp_t      fe_rsp_o,
   output cache_pkg::be_req_t      be_req_o,
   input  wire cache_pkg::be_rsp_t be_rsp_i,
   input  wire                     invalidate_i,
   output cache_pkg::stat_t        stat_o
);

   // data memory addressed by index and word offset
   localparam int DATA_ABITS = cache_pkg::ADDR_W - cache_pkg::TAG_W;

   logic                                tag_en;
   logic                                tag_we;
   logic [cache_pkg::INDEX_W-1:0]       tag_addr;
   cache_pkg::tag_entry_t               tag_d;
   cache_pkg::tag_entry_t               tag_q;
   logic                                data_en;
   logic                                data_we;
   logic [DATA_ABITS-1:0]               data_addr;
   cache_pkg::word_t                    data_d;
   cache_pkg::word_t                    data_q;
   logic                                cnt_clear;
   logic                                cnt_inc;
   logic [cache_pkg::OFFSET_W-1:0]      cnt;
   logic                                cnt_last;

   cache_ctrl ctrl (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .fe_req_i     (fe_req_i),
      .fe_rsp_o     (fe_rsp_o),
      .be_req_o     (be_req_o),
      .be_rsp_i     (be_rsp_i),
      .invalidate_i (invalidate_i),
      .stat_o       (stat_o),
      .tag_en_o     (tag_en),
      .tag_we_o     (tag_we),
      .tag_addr_o   (tag_addr),
      .tag_d_o      (tag_d),
      .tag_q_i      (tag_q),
      .data_en_o    (data_en),
      .data_we_o    (data_we),
      .data_addr_o  (data_addr),
      .data_d_o     (data_d),
      .data_q_i     (data_q),
      .cnt_clear_o  (cnt_clear),
      .cnt_inc_o    (cnt_inc),
      .cnt_i        (cnt),
      .cnt_last_i   (cnt_last)
   );

   fill_counter fill_cnt (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .clear_i  (cnt_clear),
      .inc_i    (cnt_inc),
      .count_o  (cnt),
      .last_o   (cnt_last)
   );

   cache_ram #(
      .entry_t   (cache_pkg::tag_entry_t),
      .ADDR_BITS (cache_pkg::INDEX_W)
   ) tag_ram (
      .clk_i  (clk_i),
      .en_i   (tag_en),
      .we_i   (tag_we),
      .addr_i (tag_addr),
      .d_i    (tag_d),
      .q_o    (tag_q)
   );

   cache_ram #(
      .entry_t   (cache_pkg::word_t),
      .ADDR_BITS (DATA_ABITS)
   ) data_ram (
      .clk_i  (clk_i),
      .en_i   (data_en),
      .we_i   (data_we),
      .addr_i (data_addr),
      .d_i    (data_d),
      .q_o    (data_q)
   );

endmodule

`default_nettype wire

//--- design/fill_counter.sv
`timescale 1ns/1ns
`default_nettype none

// word counter for a line refill
module fill_counter (
   input  wire                                 clk_i,
   input  wire                                 arst_n_i,
   input  wire                                 clear_i,
   input  wire                                 inc_i,
   output logic [cache_pkg::OFFSET_W-1:0]      count_o,
   output logic                                last_o
);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_o <= '0;
      end else if (clear_i) begin
         count_o <= '0;
      end else if (inc_i) begin
         count_o <= count_o + 1'b1;
      end
   end

   // top word of the line
   assign last_o = (count_o == cache_pkg::OFFSET_W'(cache_pkg::NWORDS - 1));

endmodule

`default_nettype wire

//--- tb/cache_chk.sv
`timescale 1ns/1ns
`default_nettype none

module cache_chk (
   input wire                     clk_i,
   input wire                     arst_n_i,
   input wire cache_pkg::fe_req_t fe_req_i,
   input wire cache_pkg::fe_rsp_t fe_rsp_i,
   input wire cache_pkg::be_req_t be_req_i,
   input wire cache_pkg::be_rsp_t be_rsp_i,
   input wire cache_pkg::stat_t   stat_i
);

   int   fail_cnt = 0;
   logic accept;

   // front-end handshake
   assign accept = fe_req_i.avalid && fe_rsp_i.ready;

   // back-end request held with the same fields until taken
   be_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      be_req_i.avalid && !be_rsp_i.ready |=> be_req_i.avalid && $stable(be_req_i))
      else begin
         $error("back-end request dropped or changed before it was accepted");
         fail_cnt++;
      end

   // read data only while busy, ready back on the next edge
   rvalid_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      fe_rsp_i.rvalid |=> fe_rsp_i.ready && !$past(fe_rsp_i.ready))
      else begin
         $error("read data returned while ready, or ready did not return after it");
         fail_cnt++;
      end

   // exactly one monitor pulse the cycle after acceptance, none elsewhere
   stat_one: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      accept |=> $onehot(stat_i))
      else begin
         $error("accepted request without exactly one monitor pulse");
         fail_cnt++;
      end

   stat_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !accept |=> stat_i == '0)
      else begin
         $error("monitor pulse not following an acceptance");
         fail_cnt++;
      end

endmodule

`default_nettype wire

//--- tb/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

   logic                  clk;
   logic                  arst_n;
   cache_pkg::fe_req_t    fe_req;
   cache_pkg::fe_rsp_t    fe_rsp;
   cache_pkg::be_req_t    be_req;
   cache_pkg::be_rsp_t    be_rsp;
   logic                  invalidate;
   cache_pkg::stat_t      stat;

   // back-end memory, and the reference model's own copy
   cache_pkg::word_t      be_mem [1 << cache_pkg::ADDR_W];
   cache_pkg::word_t      ref_mem [1 << cache_pkg::ADDR_W];
   cache_pkg::word_t      ref_line [1 << cache_pkg::INDEX_W][cache_pkg::NWORDS];
   cache_pkg::tag_entry_t ref_tag [1 << cache_pkg::INDEX_W];
   logic [(1 << cache_pkg::INDEX_W)-1:0] ref_valid;

   cache_pkg::word_t      exp_word_q [$];
   cache_pkg::stat_t      exp_stat_q [$];
   cache_pkg::word_t      exp_word;
   cache_pkg::stat_t      exp_stat;
   cache_pkg::addr_t      rd_addr;
   string                 test_name;
   int                    errors = 0;
   int                    test_err0 = 0;
   int                    tests = 0;
   int                    cyc = 0;
   int                    accept_cyc = 0;
   int                    be_acc = 0;
   int                    be_wait = -1;
   int                    rd_delay = 0;
   logic                  rd_pending = 1'b0;
   logic                  hung = 1'b0;
   int                    seed = 5;
   int                    max_wait = 200;

   tb_clkgen clkgen (.clk_o(clk), .arst_n_o(arst_n));

   cache_top uut (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .fe_req_i     (fe_req),
      .fe_rsp_o     (fe_rsp),
      .be_req_o     (be_req),
      .be_rsp_i     (be_rsp),
      .invalidate_i (invalidate),
      .stat_o       (stat)
   );

   bind cache_ctrl cache_chk chk (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .fe_req_i (fe_req_i),
      .fe_rsp_i (fe_rsp_o),
      .be_req_i (be_req_o),
      .be_rsp_i (be_rsp_i),
      .stat_i   (stat_o)
   );

   // fill pattern, every address bit matters
   function automatic cache_pkg::word_t pattern(input int a);
      return (a * 32'h0001_0003) ^ 32'h5A00_00A5;
   endfunction

   // shadow cache: direct mapped, write-through, no allocate on write miss
   function automatic cache_pkg::word_t ref_access(input logic we, input cache_pkg::addr_t a,
         input cache_pkg::word_t wd, output cache_pkg::stat_t st);
      cache_pkg::addr_t la;
      logic             hit;
      hit = ref_valid[a.index] && (ref_tag[a.index] == a.tag);
      st  = '0;
      la  = a;
      if (we) begin
         ref_mem[a] = wd;
         if (hit) ref_line[a.index][a.offset] = wd;
         st.wr_hit  = hit;
         st.wr_miss = !hit;
         return '0;
      end
      if (!hit) begin
         for (int i = 0; i < cache_pkg::NWORDS; i++) begin
            la.offset = i[cache_pkg::OFFSET_W-1:0];
            ref_line[a.index][i] = ref_mem[la];
         end
         ref_tag[a.index]   = a.tag;
         ref_valid[a.index] = 1'b1;
      end
      st.rd_hit  = hit;
      st.rd_miss = !hit;
      return ref_line[a.index][a.offset];
   endfunction

   task automatic check_word(input string name, input cache_pkg::word_t expected,
         input cache_pkg::word_t actual);
      if (expected !== actual) begin
         $display("[ERROR] %s: word expected %08h, actual %08h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_stat(input string name, input cache_pkg::stat_t expected,
         input cache_pkg::stat_t actual);
      if (expected !== actual) begin
         $display("[ERROR] %s: stat expected %04b, actual %04b", name, expected, actual);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = errors;
   endtask

   task automatic end_test;
      if (exp_stat_q.size() != 0 || exp_word_q.size() != 0) begin
         $display("%s: some responses never arrived", test_name);
         errors++;
         exp_stat_q.delete();
         exp_word_q.delete();
      end
      tests++;
      if (errors == test_err0) $display("%s: ok", test_name);
      else $display("%s: %0d error(s)", test_name, errors - test_err0);
   endtask

   task automatic wait_ready(input string what);
      int t;
      t = 0;
      @(negedge clk);
      while (!fe_rsp.ready && t < max_wait) begin
         @(negedge clk);
         t++;
      end
      if (!fe_rsp.ready) begin
         $display("%s: timed out, the cache never became ready %s", test_name, what);
         errors++;
         hung = 1'b1;
      end
   endtask

   // one front-end request, expectations queued before it goes out
   task automatic issue(input logic we, input cache_pkg::addr_t a, input cache_pkg::word_t wd);
      cache_pkg::stat_t st;
      cache_pkg::word_t rw;
      if (hung) return;
      rw = ref_access(we, a, wd, st);
      exp_stat_q.push_back(st);
      if (!we) exp_word_q.push_back(rw);
      @(posedge clk);
      #5;
      fe_req.avalid = 1'b1;
      fe_req.we     = we;
      fe_req.addr   = a;
      fe_req.wdata  = wd;
      wait_ready("to accept a request");
      if (hung) return;
      accept_cyc = cyc;
      @(posedge clk);
      #5;
      fe_req.avalid = 1'b0;
      wait_ready("after a request");
   endtask

   task automatic do_invalidate;
      if (hung) return;
      @(posedge clk);
      #5;
      invalidate = 1'b1;
      ref_valid  = '0;
      @(posedge clk);
      #5;
      invalidate = 1'b0;
   endtask

   always @(posedge clk) cyc <= cyc + 1;

   // back end: random ready wait, random read latency
   always @(posedge clk) begin
      #5;
      be_rsp.ready  = 1'b0;
      be_rsp.rvalid = 1'b0;
      if (rd_pending) begin
         if (rd_delay == 0) begin
            be_rsp.rvalid = 1'b1;
            be_rsp.rdata  = be_mem[rd_addr];
            rd_pending    = 1'b0;
         end else begin
            rd_delay--;
         end
      end else if (be_req.avalid) begin
         if (be_wait < 0) be_wait = $unsigned($random(seed)) % 4;
         if (be_wait == 0) begin
            be_rsp.ready = 1'b1;
            be_acc++;
            be_wait = -1;
            if (be_req.we) begin
               be_mem[be_req.addr] = be_req.wdata;
            end else begin
               rd_pending = 1'b1;
               rd_delay   = $unsigned($random(seed)) % 4;
               rd_addr    = be_req.addr;
            end
         end else begin
            be_wait--;
         end
      end
   end

   // compare every monitor pulse and every read response
   always @(negedge clk) begin
      if (arst_n && stat != '0) begin
         if (exp_stat_q.size() == 0) begin
            $display("%s: monitor pulse with no request outstanding", test_name);
            errors++;
         end else begin
            exp_stat = exp_stat_q.pop_front();
            check_stat(test_name, exp_stat, stat);
            if (cyc != accept_cyc + 1) begin
               $display("%s: monitor pulse not one cycle after acceptance", test_name);
               errors++;
            end
            if (exp_stat.rd_hit && !fe_rsp.rvalid) begin
               $display("%s: read hit data not one cycle after acceptance", test_name);
               errors++;
            end
         end
      end
      if (arst_n && fe_rsp.rvalid) begin
         if (exp_word_q.size() == 0) begin
            $display("%s: read data with no read outstanding", test_name);
            errors++;
         end else begin
            exp_word = exp_word_q.pop_front();
            check_word(test_name, exp_word, fe_rsp.rdata);
         end
      end
   end

   initial begin
      cache_pkg::addr_t a;
      logic [31:0]      r;
      cache_pkg::word_t wd;
      int               t;
      int               be_before;
      fe_req     = '0;
      be_rsp     = '0;
      invalidate = 1'b0;
      ref_valid  = '0;
      test_name  = "reset";
      for (int i = 0; i < (1 << cache_pkg::ADDR_W); i++) begin
         be_mem[i]  = pattern(i);
         ref_mem[i] = pattern(i);
      end
      t = 0;
      while (arst_n !== 1'b1 && t < max_wait) begin
         @(posedge clk);
         t++;
      end
      if (arst_n !== 1'b1) begin
         $display("reset was never released");
         errors++;
         hung = 1'b1;
      end

      begin_test("cold_read");
      issue(1'b0, {4'd3, 4'd5, 2'd2}, '0);
      end_test();

      begin_test("line_hits");
      be_before = be_acc;
      issue(1'b0, {4'd3, 4'd5, 2'd0}, '0);
      issue(1'b0, {4'd3, 4'd5, 2'd3}, '0);
      issue(1'b0, {4'd3, 4'd5, 2'd1}, '0);
      if (be_acc != be_before) begin
         $display("%s: back-end traffic during read hits", test_name);
         errors++;
      end
      end_test();

      begin_test("write_hit");
      issue(1'b1, {4'd3, 4'd5, 2'd1}, 32'hCAFE_0001);
      check_word(test_name, 32'hCAFE_0001, be_mem[{4'd3, 4'd5, 2'd1}]);
      issue(1'b0, {4'd3, 4'd5, 2'd1}, '0);
      end_test();

      begin_test("write_miss");
      issue(1'b1, {4'd6, 4'd9, 2'd0}, 32'h1234_5678);
      check_word(test_name, 32'h1234_5678, be_mem[{4'd6, 4'd9, 2'd0}]);
      issue(1'b0, {4'd6, 4'd9, 2'd0}, '0);
      end_test();

      begin_test("evict");
      issue(1'b0, {4'd3, 4'd5, 2'd0}, '0);
      issue(1'b0, {4'd7, 4'd5, 2'd0}, '0);
      issue(1'b0, {4'd3, 4'd5, 2'd0}, '0);
      end_test();

      begin_test("invalidate_random");
      issue(1'b0, {4'd2, 4'd12, 2'd3}, '0);
      issue(1'b0, {4'd2, 4'd12, 2'd3}, '0);
      do_invalidate();
      issue(1'b0, {4'd2, 4'd12, 2'd3}, '0);
      // four tags only, so lines get reused often
      for (int n = 0; n < 200; n++) begin
         r = $random(seed);
         if (r[3:0] == 4'd0) do_invalidate();
         a  = {2'b00, r[13:6]};
         wd = $random(seed);
         issue(r[5:4] == 2'd0, a, wd);
      end
      end_test();

      errors += uut.ctrl.chk.fail_cnt;
      $display("tests: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

// 40 ns clock, reset low for the first 16 cycles
module tb_clkgen (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (16) @(posedge clk_o);
      #5;
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire
